// File: y86_isa_pkg.sv
package y86_isa_pkg;

	typedef enum logic [3:0] {
		HALT   = 4'h0,
		NOP    = 4'h1,
		RRMOVQ = 4'h2, // Also the conditional moves
		IRMOVQ = 4'h3,
		RMMOVQ = 4'h4,
		MRMOVQ = 4'h5,
		OPQ    = 4'h6,
		JXX    = 4'h7,
		CALL   = 4'h8,
		RET    = 4'h9,
		PUSHQ  = 4'hA,
		POPQ   = 4'hB
	} icode_e;

	typedef enum logic [3:0] {
		RAX   = 4'h0,
		RCX   = 4'h1,
		RDX   = 4'h2,
		RBX   = 4'h3,
		RSP   = 4'h4, // Stack pointer
		RBP   = 4'h5,
		RSI   = 4'h6,
		RDI   = 4'h7,
		R8    = 4'h8,
		R9    = 4'h9,
		R10   = 4'hA,
		R11   = 4'hB,
		R12   = 4'hC,
		R13   = 4'hD,
		R14   = 4'hE,
		RNONE = 4'hF  // No register
	} reg_id_e;

	typedef enum logic [2:0] {
		SBUB = 3'h0, // Bubble
		SAOK = 3'h1,
		SHLT = 3'h2,
		SADR = 3'h3, // Bad address
		SINS = 3'h4  // Illegal instruction
	} stat_e;

endpackage

// File: y86_pipe_pkg.sv
package y86_pipe_pkg;

	import y86_isa_pkg::*;

	// Fetch to decode, 148 bits
	typedef struct packed {
		logic        valid;
		stat_e       stat;
		icode_e      icode;
		logic [3:0]  ifun;
		reg_id_e     rA;
		reg_id_e     rB;
		logic [63:0] valC;
		logic [63:0] valP;
	} d_reg_t;

	// Decode to execute, 220 bits
	typedef struct packed {
		logic        valid;
		stat_e       stat;
		icode_e      icode;
		logic [3:0]  ifun;
		logic [63:0] valC;
		logic [63:0] valA;
		logic [63:0] valB;
		reg_id_e     dstE;
		reg_id_e     dstM;
		reg_id_e     srcA;
		reg_id_e     srcB;
	} e_reg_t;

	// Results of the newer stages; W fields also drive the register file writes
	typedef struct packed {
		reg_id_e     e_dstE;
		logic [63:0] e_valE;
		reg_id_e     M_dstE;
		logic [63:0] M_valE;
		reg_id_e     M_dstM;
		logic [63:0] m_valM;
		reg_id_e     W_dstE;
		logic [63:0] W_valE;
		reg_id_e     W_dstM;
		logic [63:0] W_valM;
	} fwd_bus_t;

endpackage

// File: y86_regfile.sv
`timescale 1ns/10ps

module y86_regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  y86_isa_pkg::reg_id_e  srcA,
	input  y86_isa_pkg::reg_id_e  srcB,
	input  y86_pipe_pkg::fwd_bus_t wr,
	output logic [63:0]           rvalA,
	output logic [63:0]           rvalB
);

	import y86_isa_pkg::*;

	localparam int NREGS = 15;

	logic [63:0] regs [0:NREGS-1];

	// Port M is written last so it wins a same-register conflict
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr.W_dstE != RNONE) begin
				regs[wr.W_dstE] <= wr.W_valE;
			end
			if (wr.W_dstM != RNONE) begin
				regs[wr.W_dstM] <= wr.W_valM;
			end
		end
	end

	always_comb begin
		if (srcA == RNONE) begin
			rvalA = '0;
		end else begin
			rvalA = regs[srcA];
		end
	end

	always_comb begin
		if (srcB == RNONE) begin
			rvalB = '0;
		end else begin
			rvalB = regs[srcB];
		end
	end

endmodule

// File: y86_decode_ctrl.sv
`timescale 1ns/10ps

module y86_decode_ctrl (
	input  y86_isa_pkg::icode_e  icode,
	input  y86_isa_pkg::reg_id_e rA,
	input  y86_isa_pkg::reg_id_e rB,
	output y86_isa_pkg::reg_id_e srcA,
	output y86_isa_pkg::reg_id_e srcB,
	output y86_isa_pkg::reg_id_e dstE,
	output y86_isa_pkg::reg_id_e dstM
);

	import y86_isa_pkg::*;

	always_comb begin
		case (icode)
			RRMOVQ, RMMOVQ, OPQ, PUSHQ: srcA = rA;
			POPQ, RET:                  srcA = RSP; // Old stack top
			default:                    srcA = RNONE;
		endcase
	end

	always_comb begin
		case (icode)
			OPQ, RMMOVQ, MRMOVQ:    srcB = rB; // Also the address base
			PUSHQ, POPQ, CALL, RET: srcB = RSP;
			default:                srcB = RNONE;
		endcase
	end

	always_comb begin
		case (icode)
			RRMOVQ, IRMOVQ, OPQ:    dstE = rB;
			PUSHQ, POPQ, CALL, RET: dstE = RSP; // Updated stack pointer
			default:                dstE = RNONE;
		endcase
	end

	always_comb begin
		case (icode)
			MRMOVQ, POPQ: dstM = rA; // Loaded value
			default:      dstM = RNONE;
		endcase
	end

endmodule

// File: y86_forward.sv
`timescale 1ns/10ps

module y86_forward (
	input  y86_isa_pkg::icode_e    icode,
	input  logic [63:0]            valP,
	input  y86_isa_pkg::reg_id_e   srcA,
	input  y86_isa_pkg::reg_id_e   srcB,
	input  logic [63:0]            rvalA,
	input  logic [63:0]            rvalB,
	input  y86_pipe_pkg::fwd_bus_t fwd,
	output logic [63:0]            valA,
	output logic [63:0]            valB
);

	import y86_isa_pkg::*;
	import y86_pipe_pkg::*;

	// Newest stage first, register file last
	function automatic logic [63:0] pick(
		input reg_id_e     src,
		input logic [63:0] rval,
		input fwd_bus_t    f
	);
		logic [63:0] v;
		if (src == RNONE) begin
			v = rval;
		end else if (src == f.e_dstE) begin
			v = f.e_valE;
		end else if (src == f.M_dstM) begin
			v = f.m_valM;
		end else if (src == f.M_dstE) begin
			v = f.M_valE;
		end else if (src == f.W_dstM) begin
			v = f.W_valM;
		end else if (src == f.W_dstE) begin
			v = f.W_valE;
		end else begin
			v = rval;
		end
		return v;
	endfunction

	always_comb begin
		if (icode == CALL || icode == JXX) begin
			valA = valP; // Return address or fall-through
		end else begin
			valA = pick(srcA, rvalA, fwd);
		end
		valB = pick(srcB, rvalB, fwd);
	end

	// An unused A port carries zero from the register file
	always_comb begin
		if (srcA == RNONE && icode != CALL && icode != JXX) begin
			a_rnone_zero: assert (valA == 64'd0)
				else $error("valA not zero for RNONE source");
		end
	end

endmodule

// File: y86_decode_stage.sv
`timescale 1ns/10ps

module y86_decode_stage #(
	parameter int CREDITS = 2
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  y86_pipe_pkg::d_reg_t  d_in,
	input  y86_isa_pkg::reg_id_e  srcA,
	input  y86_isa_pkg::reg_id_e  srcB,
	input  y86_isa_pkg::reg_id_e  dstE,
	input  y86_isa_pkg::reg_id_e  dstM,
	input  logic [63:0]           valA,
	input  logic [63:0]           valB,
	input  logic                  credit_return,
	output y86_pipe_pkg::e_reg_t  e_out,
	output logic                  stall
);

	localparam int CW = $clog2(CREDITS + 1);

	logic [CW-1:0] credits;
	logic          accept;

	assign stall  = (credits == '0);
	assign accept = d_in.valid && !stall;

	// One credit per issue, one back per return pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CW'(CREDITS);
		end else begin
			case ({accept, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_out <= '0;
		end else if (accept) begin
			e_out.valid <= 1'b1;
			e_out.stat  <= d_in.stat; // Status passes straight through
			e_out.icode <= d_in.icode;
			e_out.ifun  <= d_in.ifun;
			e_out.valC  <= d_in.valC;
			e_out.valA  <= valA;
			e_out.valB  <= valB;
			e_out.dstE  <= dstE;
			e_out.dstM  <= dstM;
			e_out.srcA  <= srcA;
			e_out.srcB  <= srcB;
		end else begin
			e_out.valid <= 1'b0; // Payload holds its last value
		end
	end

	// Counter stays within the pool handed out at reset
	a_credit_max: assert property (
		@(posedge clk) disable iff (!arst_n)
		credits <= CW'(CREDITS)
	) else $error("credit count above %0d", CREDITS);

	// Execute never returns a credit it was not given
	a_no_extra_return: assert property (
		@(posedge clk) disable iff (!arst_n)
		credit_return |-> (credits != CW'(CREDITS))
	) else $error("credit_return with all credits at decode");

endmodule

// File: y86_decode_top.sv
`timescale 1ns/10ps

module y86_decode_top #(
	parameter int CREDITS = 2
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  y86_pipe_pkg::d_reg_t   d_in,
	input  y86_pipe_pkg::fwd_bus_t fwd,
	input  logic                   credit_return,
	output y86_pipe_pkg::e_reg_t   e_out,
	output logic                   stall
);

	import y86_isa_pkg::*;

	reg_id_e     srcA;
	reg_id_e     srcB;
	reg_id_e     dstE;
	reg_id_e     dstM;
	logic [63:0] rvalA;
	logic [63:0] rvalB;
	logic [63:0] valA;
	logic [63:0] valB;

	y86_decode_ctrl u_ctrl (
		.icode (d_in.icode),
		.rA    (d_in.rA),
		.rB    (d_in.rB),
		.srcA  (srcA),
		.srcB  (srcB),
		.dstE  (dstE),
		.dstM  (dstM)
	);

	y86_regfile u_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.srcA   (srcA),
		.srcB   (srcB),
		.wr     (fwd), // Write-back fields
		.rvalA  (rvalA),
		.rvalB  (rvalB)
	);

	y86_forward u_forward (
		.icode (d_in.icode),
		.valP  (d_in.valP),
		.srcA  (srcA),
		.srcB  (srcB),
		.rvalA (rvalA),
		.rvalB (rvalB),
		.fwd   (fwd),
		.valA  (valA),
		.valB  (valB)
	);

	y86_decode_stage #(
		.CREDITS (CREDITS)
	) u_stage (
		.clk           (clk),
		.arst_n        (arst_n),
		.d_in          (d_in),
		.srcA          (srcA),
		.srcB          (srcB),
		.dstE          (dstE),
		.dstM          (dstM),
		.valA          (valA),
		.valB          (valB),
		.credit_return (credit_return),
		.e_out         (e_out),
		.stall         (stall)
	);

endmodule

// File: tb_y86_decode.sv
`timescale 1ns/10ps

module tb_y86_decode;

	import y86_isa_pkg::*;
	import y86_pipe_pkg::*;

	localparam int MAX_CYCLES = 400; // About three times the test length

	logic        clk;
	logic        arst_n;
	d_reg_t      d_in;
	fwd_bus_t    fwd;
	logic        credit_return;
	e_reg_t      e_out;
	logic        stall;

	int          seed;
	int          cycles = 0;
	int          test_errors;
	int          errors;
	int          passed;
	int          failed;
	logic [63:0] model [0:14]; // Expected register file contents

	y86_decode_top #(
		.CREDITS (2)
	) uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.d_in          (d_in),
		.fwd           (fwd),
		.credit_return (credit_return),
		.e_out         (e_out),
		.stall         (stall)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Run stopped at the limit of %0d cycles, a test is stuck", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic fwd_bus_t no_fwd();
		fwd_bus_t f;
		f = '0;
		f.e_dstE = RNONE;
		f.M_dstE = RNONE;
		f.M_dstM = RNONE;
		f.W_dstE = RNONE;
		f.W_dstM = RNONE;
		return f;
	endfunction

	function automatic d_reg_t make_d(input icode_e ic, input reg_id_e ra, input reg_id_e rb,
			input logic [63:0] vc, input logic [63:0] vp);
		d_reg_t d;
		d.valid = 1'b1;
		d.stat  = SAOK;
		d.icode = ic;
		d.ifun  = 4'h0;
		d.rA    = ra;
		d.rB    = rb;
		d.valC  = vc;
		d.valP  = vp;
		return d;
	endfunction

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// {srcA, srcB, dstE, dstM} with rA = RDX and rB = RBX
	function automatic logic [15:0] expected_ids(input icode_e ic);
		case (ic)
			RRMOVQ:  return 16'h2F3F;
			IRMOVQ:  return 16'hFF3F;
			RMMOVQ:  return 16'h23FF;
			MRMOVQ:  return 16'hF3F2;
			OPQ:     return 16'h233F;
			CALL:    return 16'hF44F;
			RET:     return 16'h444F;
			PUSHQ:   return 16'h244F;
			POPQ:    return 16'h4442;
			default: return 16'hFFFF; // HALT, NOP, JXX
		endcase
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			$display("%s: ok", name);
			passed++;
		end else begin
			$display("%s: %0d errors", name, test_errors);
			failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	// One cycle on the write-back fields, port M wins a conflict
	task automatic write_regs(input reg_id_e de, input logic [63:0] ve,
			input reg_id_e dm, input logic [63:0] vm);
		fwd_bus_t f;
		f = no_fwd();
		f.W_dstE = de;
		f.W_valE = ve;
		f.W_dstM = dm;
		f.W_valM = vm;
		fwd <= f;
		@(posedge clk);
		fwd <= no_fwd();
		if (de != RNONE) model[de] = ve;
		if (dm != RNONE) model[dm] = vm;
	endtask

	task automatic issue(input string name, input d_reg_t d, output e_reg_t got, output bit seen);
		int n;
		seen = 1'b0;
		got = '0;
		d_in <= d;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (stall && n < 8); // Taken at the first edge with stall low
		d_in.valid <= 1'b0;
		n = 0;
		while (!seen && n < 4) begin
			@(posedge clk);
			n++;
			if (e_out.valid) begin
				seen = 1'b1;
				got = e_out;
			end
		end
		if (!seen) begin
			$display("%s: instruction lost, e_out.valid never rose", name);
			test_errors++;
		end else begin
			credit_return <= 1'b1; // Execute frees the slot
			@(posedge clk);
			credit_return <= 1'b0;
		end
	endtask

	task automatic reset_state();
		string  name;
		e_reg_t got;
		bit     seen;
		name = "reset_state";
		check(name, 64'd0, 64'(stall));
		check(name, 64'd0, 64'(e_out.valid));
		issue(name, make_d(OPQ, RAX, RCX, 64'h0, 64'h0), got, seen);
		if (seen) begin
			check(name, 64'd0, got.valA);
			check(name, 64'd0, got.valB);
		end
		end_test(name);
	endtask

	task automatic write_then_read();
		string       name;
		reg_id_e     ra [0:2];
		reg_id_e     rb [0:2];
		logic [63:0] va;
		logic [63:0] vb;
		e_reg_t      got;
		bit          seen;
		int          i;
		name = "write_read";
		ra = '{RDX, R8, RSI};
		rb = '{RBX, R14, R13};
		for (i = 0; i < 3; i++) begin
			va = rand64();
			vb = rand64();
			write_regs(ra[i], va, rb[i], vb);
			issue(name, make_d(OPQ, ra[i], rb[i], 64'h0, 64'h0), got, seen);
			if (seen) begin
				check(name, va, got.valA);
				check(name, vb, got.valB);
			end
		end
		va = rand64();
		vb = rand64();
		write_regs(RCX, va, RCX, vb); // Same register on both ports
		issue(name, make_d(OPQ, RCX, RCX, 64'h0, 64'h0), got, seen);
		if (seen) begin
			check(name, vb, got.valA);
			check(name, vb, got.valB);
		end
		end_test(name);
	endtask

	task automatic operand_table();
		string  name;
		icode_e ic;
		d_reg_t d;
		e_reg_t got;
		bit     seen;
		int     c;
		name = "operand_table";
		for (c = 0; c < 12; c++) begin
			ic = icode_e'(c[3:0]);
			d = make_d(ic, RDX, RBX, 64'h0, 64'h0);
			d.ifun = 4'hF - c[3:0]; // Distinct function code per instruction
			d.stat = (ic == HALT) ? SHLT : SAOK;
			issue(name, d, got, seen);
			if (seen) begin
				check(name, 64'(expected_ids(ic)),
					64'({got.srcA, got.srcB, got.dstE, got.dstM}));
				check(name, 64'(ic), 64'(got.icode));
				check(name, 64'(d.ifun), 64'(got.ifun));
				check(name, 64'(d.stat), 64'(got.stat));
			end
		end
		end_test(name);
	endtask

	task automatic forward_priority();
		string       name;
		logic [63:0] v [0:4];
		logic [63:0] exp;
		fwd_bus_t    f;
		e_reg_t      got;
		bit          seen;
		int          k;
		name = "forward_priority";
		write_regs(RBP, rand64(), RNONE, 64'h0);
		for (k = 0; k < 5; k++) begin
			v[k] = rand64();
		end
		// Drop the newest match on each pass
		for (k = 0; k <= 5; k++) begin
			f = no_fwd();
			if (k == 0) begin
				f.e_dstE = RBP;
				f.e_valE = v[0];
			end
			if (k <= 1) begin
				f.M_dstM = RBP;
				f.m_valM = v[1];
			end
			if (k <= 2) begin
				f.M_dstE = RBP;
				f.M_valE = v[2];
			end
			if (k <= 3) begin
				f.W_dstM = RBP;
				f.W_valM = v[3];
			end
			if (k <= 4) begin
				f.W_dstE = RBP;
				f.W_valE = v[4];
			end
			exp = (k < 5) ? v[k] : model[RBP];
			fwd <= f;
			issue(name, make_d(OPQ, RBP, RBP, 64'h0, 64'h0), got, seen);
			if (seen) begin
				check(name, exp, got.valA);
				check(name, exp, got.valB);
			end
			if (k <= 3) begin
				model[RBP] = v[3]; // W fields also write the register file
			end else if (k == 4) begin
				model[RBP] = v[4];
			end
		end
		fwd <= no_fwd();
		end_test(name);
	endtask

	task automatic next_address();
		string       name;
		fwd_bus_t    f;
		icode_e      ic;
		logic [63:0] vp;
		e_reg_t      got;
		bit          seen;
		int          i;
		name = "next_address";
		f = no_fwd();
		f.e_dstE = RDX; // Would hit rA if it were a source
		f.e_valE = rand64();
		fwd <= f;
		for (i = 0; i < 2; i++) begin
			ic = (i == 0) ? CALL : JXX;
			vp = rand64();
			issue(name, make_d(ic, RDX, RBX, 64'h0, vp), got, seen);
			if (seen) check(name, vp, got.valA);
		end
		fwd <= no_fwd();
		end_test(name);
	endtask

	task automatic credit_flow();
		string  name;
		d_reg_t d [0:2];
		e_reg_t outs [$];
		int     i;
		int     idx;
		int     n;
		int     stalls;
		int     pulse_at;
		int     third_at;
		bit     was_stalled;
		name = "credit_flow";
		for (i = 0; i < 3; i++) begin
			d[i] = make_d(OPQ, RAX, RCX, 64'hC0 + 64'(i), 64'h40 + 64'(i));
		end
		idx = 0;
		stalls = 0;
		pulse_at = -1;
		third_at = -1;
		was_stalled = 1'b0;
		d_in <= d[0];
		for (n = 0; n < 20 && outs.size() < 3; n++) begin
			@(posedge clk);
			credit_return <= 1'b0;
			if (e_out.valid) begin
				outs.push_back(e_out);
				if (outs.size() == 3) third_at = n;
			end
			if (stall) begin
				stalls++;
				if (stalls == 1) check(name, 64'd2, 64'(idx)); // Pool of two used up
				if (was_stalled) check(name, 64'd0, 64'(e_out.valid)); // Nothing issued while held
				if (stalls == 3) begin
					credit_return <= 1'b1;
					pulse_at = n;
				end
			end else if (d_in.valid) begin
				idx++;
				if (idx < 3) begin
					d_in <= d[idx];
				end else begin
					d_in.valid <= 1'b0;
				end
			end
			was_stalled = stall;
		end
		if (outs.size() < 3) begin
			$display("%s: instruction lost, %0d of 3 came out", name, outs.size());
			test_errors++;
		end else begin
			// Credit counted one edge on, accepted the next, visible after that
			check(name, 64'd3, 64'(third_at - pulse_at));
		end
		for (i = 0; i < outs.size(); i++) begin
			check(name, d[i].valC, outs[i].valC);
		end
		credit_return <= 1'b1; // Hand back the last two slots
		@(posedge clk);
		@(posedge clk);
		credit_return <= 1'b0;
		end_test(name);
	endtask

	initial begin
		int i;
		seed = 32'h8cb1531d;
		test_errors = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		for (i = 0; i < 15; i++) begin
			model[i] = '0;
		end
		clk = 1'b0;
		arst_n = 1'b0;
		d_in = '0;
		fwd = no_fwd();
		credit_return = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		reset_state();
		write_then_read();
		operand_table();
		forward_priority();
		next_address();
		credit_flow();
		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: y86_decode.f
y86_isa_pkg.sv
y86_pipe_pkg.sv
y86_regfile.sv
y86_decode_ctrl.sv
y86_forward.sv
y86_decode_stage.sv
y86_decode_top.sv
tb_y86_decode.sv

// File: Makefile
TOP = tb_y86_decode

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f y86_decode.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
